// File: design/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPC_W      = 7;
    localparam int F3_W       = 3;
    localparam int F7_W       = 7;

    // canonical ADDI x0,x0,0, used as the bubble
    localparam logic [XLEN-1:0] INST_NOP = 32'h0000_0013;

    // major opcodes, bits 6:0 of the word
    typedef enum logic [OPC_W-1:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111
    } opcode_e;

    // load widths
    localparam logic [F3_W-1:0] F3_LB  = 3'b000;
    localparam logic [F3_W-1:0] F3_LH  = 3'b001;
    localparam logic [F3_W-1:0] F3_LW  = 3'b010;
    localparam logic [F3_W-1:0] F3_LBU = 3'b100;
    localparam logic [F3_W-1:0] F3_LHU = 3'b101;

    // store widths
    localparam logic [F3_W-1:0] F3_SB = 3'b000;
    localparam logic [F3_W-1:0] F3_SH = 3'b001;
    localparam logic [F3_W-1:0] F3_SW = 3'b010;

    // branch conditions
    localparam logic [F3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [F3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [F3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [F3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [F3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [F3_W-1:0] F3_BGEU = 3'b111;

    // register-register funct7, M extension not supported
    localparam logic [F7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [F7_W-1:0] F7_ALT  = 7'b0100000; // sub, sra

    // register file side, 18 bits
    typedef struct packed {
        logic                  rs1_re;
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic                  rs2_re;
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic                  rd_we;
        logic [REG_ADDR_W-1:0] rd_addr;
    } reg_ctrl_t;

    // data memory side, 2 bits
    typedef struct packed {
        logic re; // also set for sb/sh read-modify-write
        logic we;
    } mem_ctrl_t;

    // decoder result, 21 bits
    typedef struct packed {
        logic      valid;
        reg_ctrl_t regs;
        mem_ctrl_t mem;
    } dec_t;

endpackage

`default_nettype wire

// File: design/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder import id_pkg::*; (
    input  wire logic [XLEN-1:0] inst_i,
    output dec_t                 dec_o
);

    opcode_e               opcode;
    logic [F3_W-1:0]       funct3;
    logic [F7_W-1:0]       funct7;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;

    // per-group pattern, gated by legal below
    logic legal;
    logic rs1_re;
    logic rs2_re;
    logic rd_we;
    logic mem_re;
    logic mem_we;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    always_comb begin
        legal  = 1'b0;
        rs1_re = 1'b0;
        rs2_re = 1'b0;
        rd_we  = 1'b0;
        mem_re = 1'b0;
        mem_we = 1'b0;

        case (opcode)
            OPC_OP_IMM: begin
                legal  = 1'b1; // every funct3 is defined
                rs1_re = 1'b1;
                rd_we  = 1'b1;
            end
            OPC_OP: begin
                legal  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                rs1_re = 1'b1;
                rs2_re = 1'b1;
                rd_we  = 1'b1;
            end
            OPC_LOAD: begin
                case (funct3)
                    F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU: begin
                        legal = 1'b1;
                    end
                    default: begin
                        legal = 1'b0;
                    end
                endcase
                rs1_re = 1'b1;
                rd_we  = 1'b1;
                mem_re = 1'b1;
            end
            OPC_STORE: begin
                case (funct3)
                    F3_SB, F3_SH: begin
                        legal  = 1'b1;
                        mem_re = 1'b1; // partial word, merge with old data
                    end
                    F3_SW: begin
                        legal = 1'b1;
                    end
                    default: begin
                        legal = 1'b0;
                    end
                endcase
                rs1_re = 1'b1;
                rs2_re = 1'b1;
                mem_we = 1'b1;
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
                        legal = 1'b1;
                    end
                    default: begin
                        legal = 1'b0;
                    end
                endcase
                rs1_re = 1'b1;
                rs2_re = 1'b1;
            end
            OPC_JAL: begin
                legal = 1'b1;
                rd_we = 1'b1; // link register
            end
            OPC_JALR: begin
                legal  = 1'b1;
                rs1_re = 1'b1;
                rd_we  = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                legal = 1'b1;
                rd_we = 1'b1;
            end
            OPC_MISC_MEM: begin
                legal = 1'b1; // fence, nothing to do here
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // addresses pass through regardless of their enables
    always_comb begin
        dec_o.valid         = legal;
        dec_o.regs.rs1_re   = legal & rs1_re;
        dec_o.regs.rs1_addr = rs1;
        dec_o.regs.rs2_re   = legal & rs2_re;
        dec_o.regs.rs2_addr = rs2;
        dec_o.regs.rd_we    = legal & rd_we;
        dec_o.regs.rd_addr  = rd;
        dec_o.mem.re        = legal & mem_re;
        dec_o.mem.we        = legal & mem_we;
    end

endmodule

`default_nettype wire

// File: design/id_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_pipe_reg import id_pkg::*; (
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire logic            jump_i,      // flush from execute
    input  wire logic            hold_i,
    input  dec_t                 dec_i,
    input  wire logic [XLEN-1:0] inst_i,
    input  wire logic [XLEN-1:0] inst_addr_i,
    output logic      [XLEN-1:0] inst_o,
    output logic      [XLEN-1:0] inst_addr_o,
    output logic                 valid_o,
    output reg_ctrl_t            reg_ctrl_o,
    output mem_ctrl_t            mem_ctrl_o
);

    logic bubble;

    assign bubble = jump_i | hold_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o     <= 1'b0;
            reg_ctrl_o  <= '0;
            mem_ctrl_o  <= '0;
            inst_o      <= INST_NOP;
            inst_addr_o <= '0;
        end else if (bubble) begin
            // nop goes down the pipe, address stays put
            valid_o    <= 1'b1;
            reg_ctrl_o <= '0;
            mem_ctrl_o <= '0;
            inst_o     <= INST_NOP;
        end else begin
            valid_o     <= dec_i.valid;
            reg_ctrl_o  <= dec_i.regs;
            mem_ctrl_o  <= dec_i.mem;
            inst_o      <= inst_i;
            inst_addr_o <= inst_addr_i;
        end
    end

endmodule

`default_nettype wire

// File: design/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire logic [XLEN-1:0] inst_i,
    input  wire logic [XLEN-1:0] inst_addr_i,
    input  wire logic            jump_i,
    input  wire logic            hold_i,
    output logic      [XLEN-1:0] inst_o,
    output logic      [XLEN-1:0] inst_addr_o,
    output logic                 valid_o,
    output reg_ctrl_t            reg_ctrl_o,
    output mem_ctrl_t            mem_ctrl_o
);

    dec_t dec; // combinational decode of inst_i

    id_decoder u_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    id_pipe_reg u_pipe_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .jump_i      (jump_i),
        .hold_i      (hold_i),
        .dec_i       (dec),
        .inst_i      (inst_i),
        .inst_addr_i (inst_addr_i),
        .inst_o      (inst_o),
        .inst_addr_o (inst_addr_o),
        .valid_o     (valid_o),
        .reg_ctrl_o  (reg_ctrl_o),
        .mem_ctrl_o  (mem_ctrl_o)
    );

endmodule

`default_nettype wire

// File: test/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb import id_pkg::*; ();

    logic            clk;
    logic            reset_i;
    logic [XLEN-1:0] inst_i;
    logic [XLEN-1:0] inst_addr_i;
    logic            jump_i;
    logic            hold_i;
    logic [XLEN-1:0] inst_o;
    logic [XLEN-1:0] inst_addr_o;
    logic            valid_o;
    reg_ctrl_t       reg_ctrl_o;
    mem_ctrl_t       mem_ctrl_o;

    int              errors;
    int              checks;
    int              seed;
    int              edge_cnt = 0;
    logic [XLEN-1:0] pc; // address for the next applied word

    id_stage dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .inst_i      (inst_i),
        .inst_addr_i (inst_addr_i),
        .jump_i      (jump_i),
        .hold_i      (hold_i),
        .inst_o      (inst_o),
        .inst_addr_o (inst_addr_o),
        .valid_o     (valid_o),
        .reg_ctrl_o  (reg_ctrl_o),
        .mem_ctrl_o  (mem_ctrl_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // expected decode straight from the instruction table
    function automatic dec_t expect_dec(input logic [XLEN-1:0] w);
        dec_t       d;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        logic       r1;
        logic       r2;
        logic       wd;
        logic       mr;
        logic       mw;
        f3 = w[14:12];
        f7 = w[31:25];
        ok = 1'b0;
        r1 = 1'b0;
        r2 = 1'b0;
        wd = 1'b0;
        mr = 1'b0;
        mw = 1'b0;
        case (w[6:0])
            7'b0010011: begin // op-imm
                ok = 1'b1;
                r1 = 1'b1;
                wd = 1'b1;
            end
            7'b0110011: begin // op, no mul/div
                ok = (f7 == 7'b0000000) || (f7 == 7'b0100000);
                r1 = 1'b1;
                r2 = 1'b1;
                wd = 1'b1;
            end
            7'b0000011: begin // load
                ok = (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
                r1 = 1'b1;
                wd = 1'b1;
                mr = 1'b1;
            end
            7'b0100011: begin // store
                ok = (f3 <= 3'b010);
                r1 = 1'b1;
                r2 = 1'b1;
                mw = 1'b1;
                mr = (f3 != 3'b010); // sb, sh merge bytes
            end
            7'b1100011: begin // branch
                ok = (f3 != 3'b010) && (f3 != 3'b011);
                r1 = 1'b1;
                r2 = 1'b1;
            end
            7'b1100111: begin // jalr
                ok = 1'b1;
                r1 = 1'b1;
                wd = 1'b1;
            end
            7'b1101111, 7'b0110111, 7'b0010111: begin // jal, lui, auipc
                ok = 1'b1;
                wd = 1'b1;
            end
            7'b0001111: begin
                ok = 1'b1;
            end
            default: begin
                ok = 1'b0;
            end
        endcase
        d.valid         = ok;
        d.regs.rs1_re   = ok & r1;
        d.regs.rs1_addr = w[19:15];
        d.regs.rs2_re   = ok & r2;
        d.regs.rs2_addr = w[24:20];
        d.regs.rd_we    = ok & wd;
        d.regs.rd_addr  = w[11:7];
        d.mem.re        = ok & mr;
        d.mem.we        = ok & mw;
        return d;
    endfunction

    function automatic logic [XLEN-1:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    // {rs1_re, rs2_re, rd_we, mem re, mem we}
    function automatic logic [4:0] out_enables();
        return {reg_ctrl_o.rs1_re, reg_ctrl_o.rs2_re, reg_ctrl_o.rd_we,
                mem_ctrl_o.re, mem_ctrl_o.we};
    endfunction

    // returns 1 ns after the next rising edge
    task automatic tick();
        int start;
        int polls;
        start = edge_cnt;
        polls = 0;
        #0.5;
        while (edge_cnt == start && polls < 25) begin
            #1;
            polls++;
        end
        if (edge_cnt == start) begin
            $display("timeout: no rising clock edge within 25 ns at %0t", $time);
            $display("** FAIL **");
            $finish;
        end else begin
            #0.5;
        end
    endtask

    task automatic mismatch(input string what, input logic [31:0] got,
                            input logic [31:0] exp, input logic [XLEN-1:0] w);
        errors++;
        $display("ERR @%0t: %s is %0h, expected %0h (inst %h)", $time, what, got, exp, w);
    endtask

    task automatic check_dec(input logic [XLEN-1:0] w, input logic [XLEN-1:0] a);
        dec_t       e;
        logic [4:0] en;
        e  = expect_dec(w);
        en = {e.regs.rs1_re, e.regs.rs2_re, e.regs.rd_we, e.mem.re, e.mem.we};
        checks++;
        if (valid_o !== e.valid) mismatch("valid_o", 32'(valid_o), 32'(e.valid), w);
        if (out_enables() !== en) mismatch("enables", 32'(out_enables()), 32'(en), w);
        if (e.regs.rs1_re && reg_ctrl_o.rs1_addr !== e.regs.rs1_addr)
            mismatch("rs1_addr", 32'(reg_ctrl_o.rs1_addr), 32'(e.regs.rs1_addr), w);
        if (e.regs.rs2_re && reg_ctrl_o.rs2_addr !== e.regs.rs2_addr)
            mismatch("rs2_addr", 32'(reg_ctrl_o.rs2_addr), 32'(e.regs.rs2_addr), w);
        if (e.regs.rd_we && reg_ctrl_o.rd_addr !== e.regs.rd_addr)
            mismatch("rd_addr", 32'(reg_ctrl_o.rd_addr), 32'(e.regs.rd_addr), w);
        if (inst_o !== w) mismatch("inst_o", inst_o, w, w);
        if (inst_addr_o !== a) mismatch("inst_addr_o", inst_addr_o, a, w);
    endtask

    task automatic check_bubble(input logic [XLEN-1:0] a);
        checks++;
        if (valid_o !== 1'b1) mismatch("bubble valid_o", 32'(valid_o), 32'd1, inst_i);
        if (out_enables() !== 5'b0) mismatch("bubble enables", 32'(out_enables()), 32'd0, inst_i);
        if (inst_o !== INST_NOP) mismatch("bubble inst_o", inst_o, INST_NOP, inst_i);
        if (inst_addr_o !== a) mismatch("bubble inst_addr_o", inst_addr_o, a, inst_i);
    endtask

    task automatic apply(input logic [XLEN-1:0] w);
        inst_i      = w;
        inst_addr_i = pc;
        tick();
        check_dec(w, pc);
        pc = pc + 32'd4;
    endtask

    task automatic check_reset_state();
        checks++;
        if (valid_o !== 1'b0) mismatch("reset valid_o", 32'(valid_o), 32'd0, inst_o);
        if (out_enables() !== 5'b0) mismatch("reset enables", 32'(out_enables()), 32'd0, inst_o);
        if (inst_o !== INST_NOP) mismatch("reset inst_o", inst_o, INST_NOP, inst_o);
        if (inst_addr_o !== 32'd0) mismatch("reset inst_addr_o", inst_addr_o, 32'd0, inst_o);
    endtask

    task automatic test_alu();
        apply(enc(7'h00, 5'd12, 5'd6, 3'b000, 5'd5, 7'b0010011)); // addi x5,x6,12
        apply(enc(7'h7f, 5'd31, 5'd1, 3'b010, 5'd2, 7'b0010011)); // slti x2,x1,-1
        apply(enc(7'h00, 5'd15, 5'd9, 3'b111, 5'd8, 7'b0010011)); // andi
        apply(enc(7'h00, 5'd3, 5'd10, 3'b001, 5'd11, 7'b0010011)); // slli
        apply(enc(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011)); // add
        apply(enc(7'h20, 5'd14, 5'd13, 3'b000, 5'd12, 7'b0110011)); // sub
        apply(enc(7'h00, 5'd17, 5'd16, 3'b100, 5'd18, 7'b0110011)); // xor
        apply(enc(7'h00, 5'd20, 5'd19, 3'b111, 5'd21, 7'b0110011)); // and
        apply(enc(7'h01, 5'd23, 5'd22, 3'b000, 5'd24, 7'b0110011)); // mul, invalid
    endtask

    task automatic test_mem();
        apply(enc(7'h00, 5'd4, 5'd2, 3'b000, 5'd7, 7'b0000011)); // lb
        apply(enc(7'h00, 5'd8, 5'd2, 3'b001, 5'd7, 7'b0000011)); // lh
        apply(enc(7'h01, 5'd0, 5'd3, 3'b010, 5'd9, 7'b0000011)); // lw
        apply(enc(7'h00, 5'd1, 5'd4, 3'b100, 5'd10, 7'b0000011)); // lbu
        apply(enc(7'h00, 5'd2, 5'd5, 3'b101, 5'd11, 7'b0000011)); // lhu
        apply(enc(7'h00, 5'd6, 5'd7, 3'b000, 5'd4, 7'b0100011)); // sb
        apply(enc(7'h00, 5'd8, 5'd9, 3'b001, 5'd0, 7'b0100011)); // sh
        apply(enc(7'h02, 5'd10, 5'd11, 3'b010, 5'd8, 7'b0100011)); // sw
        apply(enc(7'h00, 5'd1, 5'd2, 3'b011, 5'd3, 7'b0000011)); // load f3 011
        apply(enc(7'h00, 5'd1, 5'd2, 3'b011, 5'd3, 7'b0100011)); // store f3 011
    endtask

    task automatic test_flow();
        logic [2:0] br_f3 [6];
        br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int i = 0; i < 6; i++) begin
            apply(enc(7'h00, 5'(i + 3), 5'(i + 20), br_f3[i], 5'd8, 7'b1100011));
        end
        apply(enc(7'h00, 5'd5, 5'd6, 3'b010, 5'd8, 7'b1100011)); // branch f3 010
        apply(enc(7'h12, 5'd4, 5'd30, 3'b101, 5'd1, 7'b1101111)); // jal
        apply(enc(7'h00, 5'd8, 5'd5, 3'b000, 5'd1, 7'b1100111)); // jalr
        apply(enc(7'h55, 5'd10, 5'd20, 3'b011, 5'd14, 7'b0110111)); // lui
        apply(enc(7'h01, 5'd2, 5'd3, 3'b000, 5'd15, 7'b0010111)); // auipc
        apply(enc(7'h08, 5'd15, 5'd0, 3'b000, 5'd0, 7'b0001111)); // fence
        apply(enc(7'h00, 5'd1, 5'd2, 3'b000, 5'd3, 7'b1111111)); // unknown opcode
    endtask

    task automatic test_flush_hold();
        logic [XLEN-1:0] held;
        logic [XLEN-1:0] last_addr;
        held = enc(7'h00, 5'd4, 5'd3, 3'b010, 5'd0, 7'b0100011);
        apply(enc(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011));
        last_addr   = pc - 32'd4;
        inst_i      = enc(7'h00, 5'd6, 5'd5, 3'b000, 5'd7, 7'b0110011);
        inst_addr_i = pc;
        jump_i      = 1'b1;
        tick();
        jump_i = 1'b0;
        check_bubble(last_addr);
        inst_i      = held;
        inst_addr_i = pc;
        hold_i      = 1'b1;
        for (int i = 0; i < 3; i++) begin
            tick();
            check_bubble(last_addr);
        end
        hold_i = 1'b0;
        apply(held); // re-presented after the stall
    endtask

    task automatic test_random();
        logic [6:0]      opc_tab [12];
        logic [XLEN-1:0] w;
        int              idx;
        opc_tab = '{7'b0010011, 7'b0110011, 7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111,
                    7'b1100111, 7'b0110111, 7'b0010111, 7'b0001111, 7'b1111111, 7'b0000000};
        for (int n = 0; n < 200; n++) begin
            w      = $random(seed);
            idx    = $unsigned($random(seed)) % 12;
            w[6:0] = opc_tab[idx];
            apply(w);
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset_i     = 1'b1;
        inst_i      = enc(7'h00, 5'd2, 5'd1, 3'b010, 5'd4, 7'b0000011); // lw during reset
        inst_addr_i = 32'hffff_fff0;
        jump_i      = 1'b0;
        hold_i      = 1'b0;
        errors      = 0;
        checks      = 0;
        seed        = 74912;
        pc          = 32'h0000_1000;
        repeat (16) tick();
        reset_i = 1'b0;
        check_reset_state();
        test_alu();
        test_mem();
        test_flow();
        test_flush_hold();
        test_random();
        $display("checked %0d output cycles, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: id_stage.f
design/id_pkg.sv
design/id_decoder.sv
design/id_pipe_reg.sv
design/id_stage.sv
test/id_stage_tb.sv

// File: Makefile
# Verilator build and run for the decode stage testbench
# any variable can be overridden, e.g. make run LOG=my.log

TOP             ?= id_stage_tb
FILELIST        ?= id_stage.f
LOG             ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --timing
OBJ_DIR         ?= obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail, not the exit code of the model
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF '** PASS **' $(LOG); then \
		echo "no pass line found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
